//--- Makefile
sim:
	verilator --binary --timing --timescale 1ns/10ps --top-module tb_execute -f sim.f -Mdir obj_dir
	./obj_dir/Vtb_execute

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu
   import exec_pkg::*;
(
   input  wire exec_req_t       req,
   output logic [xlen-1:0]      result,
   output logic                 branch_cond
);

   logic [4:0]      shamt;
   logic            lt_signed;
   logic            lt_unsigned;
   logic            equal;
   logic [xlen-1:0] link;

   assign shamt       = req.rs2[4:0];
   assign lt_signed   = $signed(req.rs1) < $signed(req.rs2);
   assign lt_unsigned = req.rs1 < req.rs2;
   assign equal       = req.rs1 == req.rs2;

   // Return address for both jump forms.
   assign link = req.pc + 32'd4;

   always_comb begin
      result = '0;
      case (req.op)
         ADD: begin
            result = req.rs1 + req.rs2;
         end
         SUB: begin
            result = req.rs1 - req.rs2;
         end
         AND: begin
            result = req.rs1 & req.rs2;
         end
         OR: begin
            result = req.rs1 | req.rs2;
         end
         XOR: begin
            result = req.rs1 ^ req.rs2;
         end
         SLL: begin
            result = req.rs1 << shamt;
         end
         SRL: begin
            result = req.rs1 >> shamt;
         end
         SRA: begin
            result = $unsigned($signed(req.rs1) >>> shamt);
         end
         SLT: begin
            result = {{(xlen-1){1'b0}}, lt_signed};
         end
         SLTU: begin
            result = {{(xlen-1){1'b0}}, lt_unsigned};
         end
         LUI: begin
            result = req.imm;
         end
         AUIPC: begin
            result = req.pc + req.imm;
         end
         JAL, JALR: begin
            result = link;
         end
         default: begin
            // Branches and float ops leave the integer result at zero.
            result = '0;
         end
      endcase
   end

   // Branch condition, low for anything that is not a branch.
   always_comb begin
      case (req.op)
         BEQ:     branch_cond = equal;
         BNE:     branch_cond = !equal;
         BLT:     branch_cond = lt_signed;
         BGE:     branch_cond = !lt_signed;
         BLTU:    branch_cond = lt_unsigned;
         BGEU:    branch_cond = !lt_unsigned;
         default: branch_cond = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

//--- exec_pkg.sv
`default_nettype none

package exec_pkg;

   // Widths fixed by RV32 and the IEEE single format.
   localparam int xlen     = 32;
   localparam int flen     = 32;
   localparam int op_width = 5;

   localparam logic [flen-1:0] canonical_nan = 32'h7fc0_0000;

   // Explicit encodings so data files can name an opcode by number.
   typedef enum logic [op_width-1:0] {
      ADD     = 5'd0,
      SUB     = 5'd1,
      AND     = 5'd2,
      OR      = 5'd3,
      XOR     = 5'd4,
      SLL     = 5'd5,
      SRL     = 5'd6,
      SRA     = 5'd7,
      SLT     = 5'd8,
      SLTU    = 5'd9,
      LUI     = 5'd10,
      AUIPC   = 5'd11,
      JAL     = 5'd12,
      JALR    = 5'd13,
      BEQ     = 5'd14,
      BNE     = 5'd15,
      BLT     = 5'd16,
      BGE     = 5'd17,
      BLTU    = 5'd18,
      BGEU    = 5'd19,
      FSGNJ   = 5'd20,
      FSGNJN  = 5'd21,
      FSGNJX  = 5'd22,
      FMIN    = 5'd23,
      FMAX    = 5'd24,
      FEQ     = 5'd25,
      FLT     = 5'd26,
      FLE     = 5'd27,
      FMV_X_W = 5'd28,
      FMV_W_X = 5'd29
   } exec_op_e;

   // Decoded instruction with its operands already read.
   typedef struct packed {
      exec_op_e        op;
      logic [xlen-1:0] pc;
      logic [xlen-1:0] imm;
      logic [xlen-1:0] rs1;
      logic [xlen-1:0] rs2;
      logic [flen-1:0] frs1;
      logic [flen-1:0] frs2;
   } exec_req_t;

   typedef struct packed {
      logic [xlen-1:0] result;
      logic            jump_taken;
      logic [xlen-1:0] jump_dest;
   } exec_resp_t;

   // Opcodes served by the float unit.
   function automatic logic is_float_op(exec_op_e op);
      return op inside {FSGNJ, FSGNJN, FSGNJX, FMIN, FMAX,
                        FEQ, FLT, FLE, FMV_X_W, FMV_W_X};
   endfunction

endpackage

`default_nettype wire

//--- execute.sv
`timescale 1ns/10ps
`default_nettype none

module execute
   import exec_pkg::*;
(
   input  wire              clk,
   input  wire              rstn,

   input  wire              in_valid,
   output logic             in_ready,
   input  wire exec_req_t   in_req,

   output logic             out_valid,
   input  wire              out_ready,
   output exec_resp_t       out_resp
);

   logic [xlen-1:0] alu_result;
   logic            branch_cond;
   logic [flen-1:0] fpu_result;

   logic            is_jal;
   logic            is_jalr;
   logic [xlen-1:0] pc_target;
   logic [xlen-1:0] reg_target;
   exec_resp_t      resp_next;

   alu alu_i (
      .req         (in_req),
      .result      (alu_result),
      .branch_cond (branch_cond)
   );

   fpu fpu_i (
      .req    (in_req),
      .result (fpu_result)
   );

   assign is_jal  = in_req.op == JAL;
   assign is_jalr = in_req.op == JALR;

   assign pc_target  = in_req.pc + in_req.imm;
   // JALR drops bit 0 of the sum.
   assign reg_target = (in_req.rs1 + in_req.imm) & ~32'd1;

   always_comb begin
      resp_next.result     = is_float_op(in_req.op) ? fpu_result : alu_result;
      resp_next.jump_taken = is_jal || is_jalr || branch_cond;

      if (is_jalr) begin
         resp_next.jump_dest = reg_target;
      end else if (is_jal || branch_cond) begin
         resp_next.jump_dest = pc_target;
      end else begin
         resp_next.jump_dest = '0;
      end
   end

   // Room for a new item when empty or when the held one leaves now.
   assign in_ready = !out_valid || out_ready;

   always_ff @(posedge clk) begin
      if (rstn) begin
         out_valid <= 1'b0;
      end else if (in_ready) begin
         out_valid <= in_valid;
      end
   end

   // Payload only loads on an accepted request.
   always_ff @(posedge clk) begin
      if (in_valid && in_ready) begin
         out_resp <= resp_next;
      end
   end

endmodule

`default_nettype wire

//--- fpu.sv
`timescale 1ns/10ps
`default_nettype none

module fpu
   import exec_pkg::*;
(
   input  wire exec_req_t       req,
   output logic [flen-1:0]      result
);

   logic            nan1;
   logic            nan2;
   logic            eq;
   logic            lt;
   logic            le;
   logic            min_lt;
   logic [flen-1:0] fmin_val;
   logic [flen-1:0] fmax_val;
   logic            inj_sign;

   // Exponent all ones with a nonzero fraction.
   function automatic logic is_nan(logic [flen-1:0] x);
      return (x[30:23] == 8'hff) && (x[22:0] != '0);
   endfunction

   function automatic logic is_zero(logic [flen-1:0] x);
      return x[30:0] == '0;
   endfunction

   // Ordering of two non-NaN values.
   // With zero_signed set, -0 sorts below +0.
   function automatic logic float_lt(logic [flen-1:0] a, logic [flen-1:0] b,
                                     logic zero_signed);
      logic res;
      if (is_zero(a) && is_zero(b)) begin
         res = zero_signed && a[31] && !b[31];
      end else if (a[31] != b[31]) begin
         res = a[31];
      end else if (!a[31]) begin
         res = a[30:0] < b[30:0];
      end else begin
         res = a[30:0] > b[30:0];
      end
      return res;
   endfunction

   assign nan1 = is_nan(req.frs1);
   assign nan2 = is_nan(req.frs2);

   // Compares yield zero on any NaN.
   assign eq = !nan1 && !nan2 &&
               ((req.frs1 == req.frs2) || (is_zero(req.frs1) && is_zero(req.frs2)));
   assign lt = !nan1 && !nan2 && float_lt(req.frs1, req.frs2, 1'b0);
   assign le = lt || eq;

   assign min_lt = float_lt(req.frs1, req.frs2, 1'b1);

   always_comb begin
      if (nan1 && nan2) begin
         fmin_val = canonical_nan;
         fmax_val = canonical_nan;
      end else if (nan1) begin
         fmin_val = req.frs2;
         fmax_val = req.frs2;
      end else if (nan2) begin
         fmin_val = req.frs1;
         fmax_val = req.frs1;
      end else begin
         fmin_val = min_lt ? req.frs1 : req.frs2;
         fmax_val = min_lt ? req.frs2 : req.frs1;
      end
   end

   // Sign for the injection forms.
   always_comb begin
      case (req.op)
         FSGNJN:  inj_sign = !req.frs2[31];
         FSGNJX:  inj_sign = req.frs1[31] ^ req.frs2[31];
         default: inj_sign = req.frs2[31];
      endcase
   end

   always_comb begin
      case (req.op)
         FSGNJ, FSGNJN, FSGNJX: result = {inj_sign, req.frs1[30:0]};
         FMIN:                  result = fmin_val;
         FMAX:                  result = fmax_val;
         FEQ:                   result = {{(flen-1){1'b0}}, eq};
         FLT:                   result = {{(flen-1){1'b0}}, lt};
         FLE:                   result = {{(flen-1){1'b0}}, le};
         FMV_X_W:               result = req.frs1;
         FMV_W_X:               result = req.rs1;
         default:               result = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- sim.f
exec_pkg.sv
alu.sv
fpu.sv
execute.sv
tb_execute.sv

//--- tb_execute.sv
`timescale 1ns/10ps
`default_nettype none

module tb_execute
   import exec_pkg::*;
();

   localparam int vec_width   = 268;
   localparam int num_vectors = 42;
   localparam int max_stall   = 200;
   localparam int max_cycles  = 5000;

   logic       clk;
   logic       rstn;
   logic       in_valid;
   logic       in_ready;
   exec_req_t  in_req;
   logic       out_valid;
   logic       out_ready;
   exec_resp_t out_resp;

   // Request fields, then expected result, taken flag and target.
   logic [vec_width-1:0] vectors [0:63];
   logic [31:0]          rng;
   int                   accepted = 0;
   int                   received = 0;
   logic                 hold_check = 1'b0;
   logic                 latency_check = 1'b0;
   exec_resp_t           held_resp;

   execute execute_i (
      .clk       (clk),
      .rstn      (rstn),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .in_req    (in_req),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_resp  (out_resp)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic logic [31:0] next_random(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Pattern for entries the data file leaves unwritten.
   function automatic logic [vec_width-1:0] unloaded_entry(input int addr);
      return {{(vec_width-6){1'b1}}, 6'(addr)};
   endfunction

   function automatic exec_req_t req_from(input logic [vec_width-1:0] vec);
      exec_req_t req;
      req.op   = exec_op_e'(vec[264:260]);
      req.pc   = vec[259:228];
      req.imm  = vec[227:196];
      req.rs1  = vec[195:164];
      req.rs2  = vec[163:132];
      req.frs1 = vec[131:100];
      req.frs2 = vec[99:68];
      return req;
   endfunction

   task automatic stop_with_error(input string what);
      $display("%s", what);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task automatic check(input string name, input logic [31:0] got,
                        input logic [31:0] expected);
      if (got !== expected) begin
         stop_with_error($sformatf("MISMATCH time=%0t %s got=%h expected=%h",
                                   $time, name, got, expected));
      end
   endtask

   task automatic compare_resp(input exec_resp_t resp, input logic [vec_width-1:0] vec);
      check("out_resp.result", resp.result, vec[67:36]);
      check("out_resp.jump_taken", {31'd0, resp.jump_taken}, {31'd0, vec[32]});
      check("out_resp.jump_dest", resp.jump_dest, vec[31:0]);
   endtask

   // Monitor. Sees the values from just before each rising edge.
   always @(posedge clk) begin
      if (!rstn) begin
         // Back-pressure closes the input, otherwise it stays open.
         if (out_valid && !out_ready) begin
            check("in_ready", {31'd0, in_ready}, 32'd0);
         end else begin
            check("in_ready", {31'd0, in_ready}, 32'd1);
         end
         if (latency_check) begin
            check("out_valid", {31'd0, out_valid}, 32'd1);
            compare_resp(out_resp, vectors[6'(accepted - 1)]);
         end
         if (hold_check) begin
            check("out_valid", {31'd0, out_valid}, 32'd1);
            check("held out_resp.result", out_resp.result, held_resp.result);
            check("held out_resp.jump_taken", {31'd0, out_resp.jump_taken},
                  {31'd0, held_resp.jump_taken});
            check("held out_resp.jump_dest", out_resp.jump_dest, held_resp.jump_dest);
         end
         if (out_valid && out_ready) begin
            if (received >= num_vectors) begin
               stop_with_error("a response arrived with no request outstanding");
            end
            compare_resp(out_resp, vectors[6'(received)]);
            received++;
         end
         hold_check    = out_valid && !out_ready;
         held_resp     = out_resp;
         latency_check = in_valid && in_ready;
         if (in_valid && in_ready) begin
            accepted++;
         end
      end
   end

   initial begin
      int idx;
      int stall;
      int cycles;
      rstn      = 1'b1;
      in_valid  = 1'b0;
      in_req    = '0;
      out_ready = 1'b0;
      rng       = 32'hd855_b1c4;
      for (int i = 0; i < 64; i++) begin
         vectors[6'(i)] = unloaded_entry(i);
      end
      $readmemh("testdata.hex", vectors);
      if (vectors[6'(num_vectors - 1)] === unloaded_entry(num_vectors - 1) ||
          vectors[6'(num_vectors)] !== unloaded_entry(num_vectors)) begin
         stop_with_error("test data file is missing or has the wrong number of entries");
      end

      repeat (10) @(posedge clk);
      @(negedge clk);
      rstn = 1'b0;
      @(negedge clk);
      check("out_valid", {31'd0, out_valid}, 32'd0);
      check("in_ready", {31'd0, in_ready}, 32'd1);

      // Driver. Random idle cycles and random back-pressure.
      idx    = 0;
      stall  = 0;
      cycles = 0;
      while (idx < num_vectors) begin
         @(negedge clk);
         cycles++;
         if (cycles > max_cycles) begin
            stop_with_error("driver did not send all requests in time");
         end
         if (in_valid && accepted > idx) begin
            idx++;
            in_valid = 1'b0;
            stall    = 0;
         end else if (in_valid) begin
            stall++;
            if (stall > max_stall) begin
               stop_with_error("a request was not accepted in time");
            end
         end
         rng       = next_random(rng);
         out_ready = rng[0] | rng[1];
         if (!in_valid && idx < num_vectors && rng[4:2] != 3'd0) begin
            in_req   = req_from(vectors[6'(idx)]);
            in_valid = 1'b1;
         end
      end

      cycles = 0;
      while (received < num_vectors) begin
         @(negedge clk);
         cycles++;
         if (cycles > max_stall) begin
            stop_with_error("responses did not all arrive in time");
         end
         rng       = next_random(rng);
         out_ready = rng[0] | rng[1];
      end

      // A few more cycles to catch a stray response.
      out_ready = 1'b1;
      repeat (4) @(negedge clk);
      if (accepted == num_vectors && received == num_vectors && !out_valid) begin
         $display("TEST OK");
         $finish;
      end else begin
         stop_with_error("request or response count differs from the test data");
      end
   end

endmodule

`default_nettype wire

//--- testdata.hex
// op_pc_imm_rs1_rs2_frs1_frs2 then expected result_taken_dest
// op is the exec_op_e encoding, taken is one hex digit
00_00000000_00000000_00000005_00000007_00000000_00000000_0000000c_0_00000000
01_00000000_00000000_00000003_00000005_00000000_00000000_fffffffe_0_00000000
02_00000000_00000000_f0f0f0f0_0ff00ff0_00000000_00000000_00f000f0_0_00000000
03_00000000_00000000_f0f0f0f0_0ff00ff0_00000000_00000000_fff0fff0_0_00000000
04_00000000_00000000_f0f0f0f0_0ff00ff0_00000000_00000000_ff00ff00_0_00000000
05_00000000_00000000_00000001_0000002f_00000000_00000000_00008000_0_00000000
06_00000000_00000000_80000000_00000004_00000000_00000000_08000000_0_00000000
07_00000000_00000000_80000000_00000004_00000000_00000000_f8000000_0_00000000
08_00000000_00000000_ffffffff_00000001_00000000_00000000_00000001_0_00000000
09_00000000_00000000_ffffffff_00000001_00000000_00000000_00000000_0_00000000
0a_00000000_12345000_00000000_00000000_00000000_00000000_12345000_0_00000000
0b_00001000_00002000_00000000_00000000_00000000_00000000_00003000_0_00000000
0c_00001000_00000100_00000000_00000000_00000000_00000000_00001004_1_00001100
0d_00002000_00000004_00003001_00000000_00000000_00000000_00002004_1_00003004
0e_00001000_fffffff0_00000005_00000005_00000000_00000000_00000000_1_00000ff0
0e_00001000_fffffff0_00000005_00000006_00000000_00000000_00000000_0_00000000
0f_00001000_fffffff0_00000005_00000006_00000000_00000000_00000000_1_00000ff0
0f_00001000_fffffff0_00000005_00000005_00000000_00000000_00000000_0_00000000
10_00001000_00000020_ffffffff_00000001_00000000_00000000_00000000_1_00001020
10_00001000_00000020_00000001_ffffffff_00000000_00000000_00000000_0_00000000
11_00001000_00000020_00000007_00000007_00000000_00000000_00000000_1_00001020
11_00001000_00000020_ffffffff_00000001_00000000_00000000_00000000_0_00000000
12_00001000_00000020_00000001_ffffffff_00000000_00000000_00000000_1_00001020
12_00001000_00000020_ffffffff_00000001_00000000_00000000_00000000_0_00000000
13_00001000_00000020_ffffffff_00000001_00000000_00000000_00000000_1_00001020
13_00001000_00000020_00000001_ffffffff_00000000_00000000_00000000_0_00000000
14_00000000_00000000_00000000_00000000_3f800000_c0000000_bf800000_0_00000000
15_00000000_00000000_00000000_00000000_3f800000_c0000000_3f800000_0_00000000
16_00000000_00000000_00000000_00000000_bf800000_c0000000_3f800000_0_00000000
17_00000000_00000000_00000000_00000000_00000000_80000000_80000000_0_00000000
18_00000000_00000000_00000000_00000000_80000000_00000000_00000000_0_00000000
17_00000000_00000000_00000000_00000000_7fc00000_3f800000_3f800000_0_00000000
18_00000000_00000000_00000000_00000000_7f800001_ffc00000_7fc00000_0_00000000
17_00000000_00000000_00000000_00000000_c0000000_3f800000_c0000000_0_00000000
19_00000000_00000000_00000000_00000000_80000000_00000000_00000001_0_00000000
19_00000000_00000000_00000000_00000000_7fc00000_7fc00000_00000000_0_00000000
1a_00000000_00000000_00000000_00000000_c0000000_bf800000_00000001_0_00000000
1a_00000000_00000000_00000000_00000000_80000000_00000000_00000000_0_00000000
1b_00000000_00000000_00000000_00000000_80000000_00000000_00000001_0_00000000
1b_00000000_00000000_00000000_00000000_3f800000_7fc00000_00000000_0_00000000
1c_00000000_00000000_00000000_00000000_deadbeef_00000000_deadbeef_0_00000000
1d_00000000_00000000_cafef00d_00000000_00000000_00000000_cafef00d_0_00000000
